// File: include/rv_boot_settings.svh
/* boot timing and image size, RAM depth,
   address of the memory-mapped output port */

`ifndef RV_BOOT_SETTINGS_SVH
`define RV_BOOT_SETTINGS_SVH

// clk cycles before the flash is selected
`define RV_STARTUP_WAIT 16

// bytes copied from flash into RAM
`define RV_BOOT_BYTES 256

// RAM depth in 32-bit words
`define RV_RAM_WORDS 1024

// stores here go to io_data, not RAM
`define RV_IO_ADDR 32'h0000_FFF0

`endif

// File: hw/rv_pkg.sv
/* shared types: access sizes, RAM request and response,
   opcodes and the two-view instruction word */

`default_nettype none

package rv_pkg;

  typedef enum logic [1:0] {
    SZ_NONE = 2'd0,
    SZ_BYTE = 2'd1,
    SZ_HALF = 2'd2,
    SZ_WORD = 2'd3
  } size_e;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef struct packed {
    size_e       wr_size;   // SZ_NONE when not a write
    size_e       rd_size;   // SZ_NONE when not a read
    logic        sign_ext;  // sign extend byte and half reads
    logic [31:0] addr;      // byte address
    logic [31:0] wdata;     // data in the low lanes
  } ram_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // already extended
  } ram_rsp_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

// File: hw/flash_loader.sv
/* SPI flash boot loader: power-up wait, read command and address,
   data shift and word writes into RAM */

`timescale 1ns/1ns
`default_nettype none

`include "rv_boot_settings.svh"

module flash_loader (
  input  logic             clk,
  input  logic             rst_n,
  output logic             flash_clk,
  output logic             flash_mosi,
  output logic             flash_cs,
  input  logic             flash_miso,
  output rv_pkg::ram_req_t boot_req,
  output logic             boot_valid,
  input  logic             boot_ready,
  output logic             boot_done
);

  localparam logic [5:0] ST_WAIT  = 6'b000001;
  localparam logic [5:0] ST_CMD   = 6'b000010;
  localparam logic [5:0] ST_ADDR  = 6'b000100;
  localparam logic [5:0] ST_DATA  = 6'b001000;
  localparam logic [5:0] ST_WRITE = 6'b010000;
  localparam logic [5:0] ST_DONE  = 6'b100000;

  logic [5:0]  state;
  logic [31:0] cnt;      // power-up wait
  logic        phase;    // 0 drives flash_clk low, 1 drives it high
  logic [4:0]  bit_cnt;  // wraps every 32 bits
  logic [31:0] sr;       // command out, then data in
  logic [31:0] wr_addr;

  always_ff @(posedge clk) begin
    if (state == ST_WAIT) begin
      sr <= {8'h03, 24'h00_0000};  // read command, address 0
    end else if ((state == ST_CMD || state == ST_ADDR) && !phase) begin
      sr <= {sr[30:0], 1'b0};
    end else if (state == ST_DATA && phase) begin
      sr <= {sr[30:0], flash_miso};  // sample on rising flash_clk
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_WAIT;
      cnt        <= '0;
      phase      <= 1'b0;
      bit_cnt    <= '0;
      flash_clk  <= 1'b0;
      flash_mosi <= 1'b0;
      flash_cs   <= 1'b1;
      wr_addr    <= '0;
      boot_done  <= 1'b0;
    end else begin
      case (state)
        ST_WAIT: begin
          if (cnt == `RV_STARTUP_WAIT - 1) begin
            flash_cs <= 1'b0;
            state    <= ST_CMD;
          end else begin
            cnt <= cnt + 1;
          end
        end
        ST_CMD, ST_ADDR, ST_DATA: begin
          phase <= ~phase;
          if (!phase) begin
            flash_clk <= 1'b0;
            if (state != ST_DATA) begin
              flash_mosi <= sr[31];  // MSB first
            end
          end else begin
            flash_clk <= 1'b1;
            bit_cnt   <= bit_cnt + 5'd1;
            if (state == ST_CMD && bit_cnt == 5'd7) begin
              state <= ST_ADDR;
            end else if (state == ST_ADDR && bit_cnt == 5'd31) begin
              state <= ST_DATA;
            end else if (state == ST_DATA && bit_cnt == 5'd31) begin
              state <= ST_WRITE;  // four bytes in
            end
          end
        end
        ST_WRITE: begin
          if (boot_ready) begin
            wr_addr <= wr_addr + 32'd4;
            if (wr_addr == `RV_BOOT_BYTES - 4) begin
              flash_cs  <= 1'b1;
              boot_done <= 1'b1;
              state     <= ST_DONE;
            end else begin
              state <= ST_DATA;
            end
          end
        end
        ST_DONE: begin
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

  // first byte received lands in the low lane
  always_comb begin
    boot_req.wr_size  = rv_pkg::SZ_WORD;
    boot_req.rd_size  = rv_pkg::SZ_NONE;
    boot_req.sign_ext = 1'b0;
    boot_req.addr     = wr_addr;
    boot_req.wdata    = {sr[7:0], sr[15:8], sr[23:16], sr[31:24]};
  end

  assign boot_valid = (state == ST_WRITE);

  a_cs_stays_high: assert property (@(posedge clk) disable iff (!rst_n)
    boot_done |=> boot_done && flash_cs);

endmodule

`default_nettype wire

// File: hw/reg_file.sv
/* integer register file, x1..x31 writable, x0 reads zero */

`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_data,
  input  logic        rd_we
);

  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/rv_core.sv
/* multi-cycle RV32I subset core: fetch, execute, load and store
   states with decode, ALU and branch compare */

`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  output rv_pkg::ram_req_t core_req,
  output logic             core_valid,
  input  logic             core_ready,
  input  rv_pkg::ram_rsp_t core_rsp,
  input  logic             core_rsp_valid
);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_FETCH      = 3'd1;
  localparam logic [2:0] ST_FETCH_WAIT = 3'd2;
  localparam logic [2:0] ST_EXEC       = 3'd3;
  localparam logic [2:0] ST_LOAD       = 3'd4;
  localparam logic [2:0] ST_LOAD_WAIT  = 3'd5;
  localparam logic [2:0] ST_LOAD_WB    = 3'd6;
  localparam logic [2:0] ST_STORE      = 3'd7;

  logic [2:0]       state;
  logic [31:0]      pc;
  rv_pkg::instr_u   ir;
  logic [31:0]      load_data;
  rv_pkg::ram_req_t mem_req;  // pending load or store
  logic [31:0]      rs1_data, rs2_data;
  logic [31:0]      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0]      opb, alu, rd_val, pc_next;
  logic             wr_rd, taken, lt, ltu, rd_we;

  function automatic rv_pkg::size_e size_of(input logic [2:0] f3);
    case (f3[1:0])
      2'd0:    return rv_pkg::SZ_BYTE;
      2'd1:    return rv_pkg::SZ_HALF;
      default: return rv_pkg::SZ_WORD;
    endcase
  endfunction

  // immediates from the two views of the word
  assign imm_i = {{20{ir.i.imm12[11]}}, ir.i.imm12};
  assign imm_s = {{20{ir.r.funct7[6]}}, ir.r.funct7, ir.r.rd};
  assign imm_b = {{20{ir.r.funct7[6]}}, ir.r.rd[0], ir.r.funct7[5:0], ir.r.rd[4:1], 1'b0};
  assign imm_u = {ir.i.imm12, ir.i.rs1, ir.i.funct3, 12'd0};
  assign imm_j = {{12{ir.i.imm12[11]}}, ir.i.rs1, ir.i.funct3, ir.i.imm12[0],
                  ir.i.imm12[10:1], 1'b0};

  assign opb = (ir.r.opcode == rv_pkg::OP_REG) ? rs2_data : imm_i;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (ir.r.funct3)
      3'd0: alu = (ir.r.opcode == rv_pkg::OP_REG && ir.r.funct7[5]) ?
                  rs1_data - opb : rs1_data + opb;  // SUB only for reg-reg
      3'd1: alu = rs1_data << opb[4:0];
      3'd2: alu = {31'd0, $signed(rs1_data) < $signed(opb)};
      3'd3: alu = {31'd0, rs1_data < opb};
      3'd4: alu = rs1_data ^ opb;
      3'd5: alu = ir.r.funct7[5] ? $unsigned($signed(rs1_data) >>> opb[4:0]) :
                  rs1_data >> opb[4:0];
      3'd6: alu = rs1_data | opb;
      default: alu = rs1_data & opb;
    endcase
    case (ir.r.funct3)
      3'd0: taken = (rs1_data == rs2_data);
      3'd1: taken = (rs1_data != rs2_data);
      3'd4: taken = lt;
      3'd5: taken = !lt;
      3'd6: taken = ltu;
      3'd7: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    pc_next = pc + 32'd4;
    rd_val  = alu;
    wr_rd   = 1'b0;
    case (ir.r.opcode)
      rv_pkg::OP_LUI: begin
        rd_val = imm_u;
        wr_rd  = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        rd_val = pc + imm_u;
        wr_rd  = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        rd_val  = pc + 32'd4;
        wr_rd   = 1'b1;
        pc_next = pc + imm_j;
      end
      rv_pkg::OP_JALR: begin
        rd_val  = pc + 32'd4;
        wr_rd   = 1'b1;
        pc_next = (rs1_data + imm_i) & ~32'd1;
      end
      rv_pkg::OP_BRANCH: if (taken) pc_next = pc + imm_b;
      rv_pkg::OP_IMM, rv_pkg::OP_REG: wr_rd = 1'b1;
      default: ;
    endcase
  end

  assign rd_we = (state == ST_EXEC && wr_rd) || state == ST_LOAD_WB;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          pc <= '0;
          if (start) state <= ST_FETCH;
        end
        ST_FETCH:      if (core_ready) state <= ST_FETCH_WAIT;
        ST_FETCH_WAIT: if (core_rsp_valid) state <= ST_EXEC;
        ST_EXEC: begin
          pc <= pc_next;
          if (ir.r.opcode == rv_pkg::OP_LOAD) state <= ST_LOAD;
          else if (ir.r.opcode == rv_pkg::OP_STORE) state <= ST_STORE;
          else state <= ST_FETCH;
        end
        ST_LOAD:      if (core_ready) state <= ST_LOAD_WAIT;
        ST_LOAD_WAIT: if (core_rsp_valid) state <= ST_LOAD_WB;
        ST_LOAD_WB:   state <= ST_FETCH;
        default:      if (core_ready) state <= ST_FETCH;  // store
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_FETCH_WAIT && core_rsp_valid) ir <= core_rsp.rdata;
    if (state == ST_LOAD_WAIT && core_rsp_valid) load_data <= core_rsp.rdata;
    if (state == ST_EXEC) begin
      mem_req.addr     <= rs1_data + ((ir.r.opcode == rv_pkg::OP_STORE) ? imm_s : imm_i);
      mem_req.wdata    <= rs2_data;
      mem_req.sign_ext <= !ir.r.funct3[2];  // LBU and LHU clear it
      mem_req.wr_size  <= (ir.r.opcode == rv_pkg::OP_STORE) ?
                          size_of(ir.r.funct3) : rv_pkg::SZ_NONE;
      mem_req.rd_size  <= (ir.r.opcode == rv_pkg::OP_LOAD) ?
                          size_of(ir.r.funct3) : rv_pkg::SZ_NONE;
    end
  end

  always_comb begin
    core_req = mem_req;
    if (state == ST_FETCH) begin
      core_req.wr_size  = rv_pkg::SZ_NONE;
      core_req.rd_size  = rv_pkg::SZ_WORD;
      core_req.sign_ext = 1'b0;
      core_req.addr     = pc;
    end
  end

  assign core_valid = (state == ST_FETCH || state == ST_LOAD || state == ST_STORE);

  reg_file u_regs (
    .clk      (clk),
    .rs1      (ir.i.rs1),
    .rs2      (ir.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (ir.r.rd),
    .rd_data  ((state == ST_LOAD_WB) ? load_data : rd_val),
    .rd_we    (rd_we)
  );

  a_idle_before_start: assert property (@(posedge clk) disable iff (!rst_n)
    !start |-> !core_valid);

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    core_valid && !core_ready |=> core_valid && $stable(core_req));

endmodule

`default_nettype wire

// File: hw/ram_io.sv
/* memory front end: loader or core select, word RAM with byte and
   half lanes, read extension, output port decode and led */

`timescale 1ns/1ns
`default_nettype none

`include "rv_boot_settings.svh"

module ram_io (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::ram_req_t boot_req,
  input  logic             boot_valid,
  output logic             boot_ready,
  input  logic             boot_done,
  input  rv_pkg::ram_req_t core_req,
  input  logic             core_valid,
  output logic             core_ready,
  output rv_pkg::ram_rsp_t core_rsp,
  output logic             core_rsp_valid,
  output logic             led,
  output logic [31:0]      io_data,
  output logic             io_valid
);

  localparam int AW = $clog2(`RV_RAM_WORDS);

  logic [31:0]      mem [`RV_RAM_WORDS];
  rv_pkg::ram_req_t req;
  logic             rdy, accept, wr_accept, rd_accept, is_io;
  logic [3:0]       be;
  logic [31:0]      wlane, rd_word, lane_word;
  rv_pkg::size_e    rd_size_q;
  logic             rd_sign_q;
  logic [1:0]       rd_lane_q;

  assign req        = boot_done ? core_req : boot_req;  // loader until boot_done
  assign accept     = rdy && (boot_done ? core_valid : boot_valid);
  assign wr_accept  = accept && req.wr_size != rv_pkg::SZ_NONE;
  assign rd_accept  = accept && req.rd_size != rv_pkg::SZ_NONE;
  assign is_io      = (req.addr == `RV_IO_ADDR);
  assign boot_ready = rdy && !boot_done;
  assign core_ready = rdy && boot_done;

  always_comb begin
    case (req.wr_size)
      rv_pkg::SZ_BYTE: begin
        be    = 4'b0001 << req.addr[1:0];
        wlane = {4{req.wdata[7:0]}};
      end
      rv_pkg::SZ_HALF: begin
        be    = 4'b0011 << {req.addr[1], 1'b0};
        wlane = {2{req.wdata[15:0]}};
      end
      rv_pkg::SZ_WORD: begin
        be    = 4'b1111;
        wlane = req.wdata;
      end
      default: begin
        be    = 4'b0000;
        wlane = req.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_accept && !is_io) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) mem[req.addr[AW+1:2]][8*b +: 8] <= wlane[8*b +: 8];
      end
    end
    if (rd_accept) begin
      rd_word   <= mem[req.addr[AW+1:2]];
      rd_size_q <= req.rd_size;
      rd_sign_q <= req.sign_ext;
      rd_lane_q <= req.addr[1:0];
    end
    if (wr_accept && is_io) io_data <= req.wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy            <= 1'b0;
      core_rsp_valid <= 1'b0;
      io_valid       <= 1'b0;
      led            <= 1'b1;
    end else begin
      rdy            <= 1'b1;
      core_rsp_valid <= rd_accept;
      io_valid       <= wr_accept && is_io;
      led            <= ~boot_done;
    end
  end

  // shift the addressed lane down, then extend
  assign lane_word = rd_word >> {rd_lane_q, 3'b000};

  always_comb begin
    case (rd_size_q)
      rv_pkg::SZ_BYTE: core_rsp.rdata = {{24{rd_sign_q & lane_word[7]}}, lane_word[7:0]};
      rv_pkg::SZ_HALF: core_rsp.rdata = {{16{rd_sign_q & lane_word[15]}}, lane_word[15:0]};
      default:         core_rsp.rdata = rd_word;
    endcase
  end

  a_rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid |->
      $past(core_valid && core_ready && core_req.rd_size != rv_pkg::SZ_NONE));

endmodule

`default_nettype wire

// File: hw/rv_soc.sv
/* top level: flash loader, core and memory front end */

`timescale 1ns/1ns
`default_nettype none

module rv_soc (
  input  logic        clk,
  input  logic        rst_n,
  output logic        flash_clk,
  output logic        flash_mosi,
  output logic        flash_cs,
  input  logic        flash_miso,
  output logic        led,
  output logic [31:0] io_data,
  output logic        io_valid
);

  rv_pkg::ram_req_t boot_req, core_req;
  rv_pkg::ram_rsp_t core_rsp;
  logic             boot_valid, boot_ready, boot_done;
  logic             core_valid, core_ready, core_rsp_valid;

  flash_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso),
    .boot_req   (boot_req),
    .boot_valid (boot_valid),
    .boot_ready (boot_ready),
    .boot_done  (boot_done)
  );

  rv_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (boot_done),  // runs once the image is in RAM
    .core_req       (core_req),
    .core_valid     (core_valid),
    .core_ready     (core_ready),
    .core_rsp       (core_rsp),
    .core_rsp_valid (core_rsp_valid)
  );

  ram_io u_ram_io (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_req       (boot_req),
    .boot_valid     (boot_valid),
    .boot_ready     (boot_ready),
    .boot_done      (boot_done),
    .core_req       (core_req),
    .core_valid     (core_valid),
    .core_ready     (core_ready),
    .core_rsp       (core_rsp),
    .core_rsp_valid (core_rsp_valid),
    .led            (led),
    .io_data        (io_data),
    .io_valid       (io_valid)
  );

endmodule

`default_nettype wire

// File: bench/spi_flash_model.sv
/* behavioral SPI flash: takes the read command and address,
   then streams the boot image from the golden file */

`timescale 1ns/1ns
`default_nettype none

`include "rv_boot_settings.svh"

module spi_flash_model (
  input  logic flash_clk,
  input  logic flash_mosi,
  input  logic flash_cs,
  output logic flash_miso
);

  logic [31:0] image [0:127];
  logic [7:0]  cmd;
  int          rises;  // rising flash_clk edges in this select
  int          dbit;   // next data bit to send

  initial begin
    for (int i = 0; i < 128; i++) begin
      image[i] = 32'd0;
    end
    $readmemh("bench/rv_soc_golden.hex", image);
    flash_miso = 1'b0;
    cmd        = 8'd0;
    rises      = 0;
    dbit       = 0;
  end

  always @(posedge flash_clk) begin
    if (flash_cs === 1'b0) begin
      if (rises < 8) cmd = {cmd[6:0], flash_mosi};
      rises = rises + 1;
    end
  end

  // bytes go out little-endian per word, MSB first within a byte
  always @(negedge flash_clk) begin
    if (flash_cs === 1'b0 && rises >= 32 && cmd == 8'h03 && dbit < `RV_BOOT_BYTES * 8) begin
      flash_miso <= image[dbit / 32][8 * ((dbit / 8) % 4) + 7 - (dbit % 8)];
      dbit = dbit + 1;
    end
  end

  always @(posedge flash_cs) begin
    rises = 0;
    dbit  = 0;
  end

endmodule

`default_nettype wire

// File: bench/tb_rv_soc.sv
/* testbench for rv_soc: boot command and completion on the flash pins,
   output-port values against the golden file, timeout */

`timescale 1ns/1ns
`default_nettype none

`include "rv_boot_settings.svh"

module tb_rv_soc;

  localparam int CYCLE_LIMIT = 20000;
  localparam int BASE        = `RV_BOOT_BYTES / 4;  // count sits after the image
  localparam int N_ALU       = 12;
  localparam int N_MEM       = 5;
  localparam int N_CTL       = 6;

  logic        clk, rst_n, flash_clk, flash_mosi, flash_cs, flash_miso, led, io_valid;
  logic [31:0] io_data;
  logic [31:0] golden [0:127];
  logic [31:0] io_q [$];
  logic [31:0] cmd_bits;
  int          fclk_rises, cycles, errors, tests_run, tests_failed, err_mark;

  rv_soc UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso),
    .led        (led),
    .io_data    (io_data),
    .io_valid   (io_valid)
  );

  spi_flash_model u_flash (
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  always @(posedge flash_clk) begin
    if (flash_cs === 1'b0) begin
      if (fclk_rises < 32) cmd_bits = {cmd_bits[30:0], flash_mosi};
      fclk_rises = fclk_rises + 1;
    end
  end

  always @(negedge clk) begin
    if (rst_n && io_valid === 1'b1) io_q.push_back(io_data);  // one entry per pulse
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
    err_mark = errors;
  endtask

  task automatic compare_outputs(input string name, input int first, input int n);
    for (int k = first; k < first + n; k++) begin
      if (k >= io_q.size()) begin
        $display("%s: output %0d never appeared on the port", name, k);
        errors++;
      end else begin
        check_value($sformatf("%s output %0d", name, k), io_q[k], golden[BASE + 1 + k]);
      end
    end
  endtask

  initial begin
    for (int i = 0; i < 128; i++) begin
      golden[i] = 32'd0;
    end
    $readmemh("bench/rv_soc_golden.hex", golden);
    rst_n      = 1'b0;
    cmd_bits   = 32'd0;
    fclk_rises = 0;
    cycles     = 0;
    errors     = 0;
    tests_run  = 0;
    tests_failed = 0;
    err_mark   = 0;
    repeat (8) @(negedge clk);
    check_value("flash_cs in reset", {31'd0, flash_cs}, 32'd1);
    check_value("led in reset", {31'd0, led}, 32'd1);
    check_value("io_valid in reset", {31'd0, io_valid}, 32'd0);
    rst_n = 1'b1;

    wait (fclk_rises >= 32);
    @(negedge clk);
    check_value("read command and address", cmd_bits, 32'h0300_0000);
    end_test("boot command");

    @(posedge flash_cs);
    @(negedge clk);
    check_value("data clocks", fclk_rises - 32, `RV_BOOT_BYTES * 8);
    check_value("outputs during boot", io_q.size(), 32'd0);
    check_value("led at boot end", {31'd0, led}, 32'd1);
    @(negedge clk);
    check_value("led after boot", {31'd0, led}, 32'd0);  // registered one cycle later
    end_test("boot completion");

    while (io_q.size() < golden[BASE]) @(negedge clk);
    repeat (500) @(negedge clk);
    compare_outputs("alu", 0, N_ALU);
    end_test("alu and upper immediate");
    compare_outputs("memory", N_ALU, N_MEM);
    end_test("memory access");
    compare_outputs("control", N_ALU + N_MEM, N_CTL);
    end_test("control flow");
    check_value("output count", io_q.size(), golden[BASE]);
    end_test("output count");

    $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/rv_soc_golden.hex
// words 0x00-0x3f: boot image, four instruction words per line
// word 0x40: count of expected outputs, then the expected output values in order
00010FB7 FF0F8F93 FFB00113 00C00193
06410093 001FA023 00012093 001FA023
00513093 001FA023 0FF1C093 001FA023
1011E093 001FA023 00419093 001FA023
40115093 001FA023 003100B3 001FA023
403100B3 001FA023 003170B3 001FA023
ABCDE0B7 001FA023 00001097 001FA023
20000293 87654237 32120213 0042A023
00229223 00228323 00328083 001FA023
00429083 001FA023 0062C083 001FA023
0022D083 001FA023 0002A083 001FA023
00210463 000FA023 003FA023 00314463
000FA023 002FA023 00317463 000FA023
005FA023 00315463 004FA023 00C003EF
007FA023 0000006F 01FFA023 00038067
00000000 00000000 00000000 00000000
@40
00000017
// alu and upper immediate
0000005F 00000001 00000000 000000F3
0000010D 000000C0 FFFFFFFD 00000007
FFFFFFEF 00000008 ABCDE000 00001068
// memory access
FFFFFF87 FFFFFFFB 000000FB 00008765
87654321
// control flow markers
0000000C FFFFFFFB 00000200 87654321
0000FFF0 000000E0

// File: rv_soc.f
+incdir+include
hw/rv_pkg.sv
hw/flash_loader.sv
hw/reg_file.sv
hw/rv_core.sv
hw/ram_io.sv
hw/rv_soc.sv
bench/spi_flash_model.sv
bench/tb_rv_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the rv_soc testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rv_soc.f \
  --top-module tb_rv_soc \
  --Mdir obj_dir \
  -o sim_rv_soc

./obj_dir/sim_rv_soc > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
